// File: logic/ctrl_pkg.sv
// shared types of the control unit; fast interrupt causes cover indices 0 to 14 only
package ctrl_pkg;

  ////////////////////
  // FSM and selectors
  ////////////////////

  // control FSM states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    IRQ_TAKEN,
    FLUSH
  } ctrl_fsm_e;

  // fetch address select, valid only with pc_set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3
  } pc_sel_e;

  // trap vector select inside the exception PC
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  // mcause encoding, bit 5 marks an interrupt
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 6'h00,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'h05,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07,
    EXC_CAUSE_ECALL_UMODE        = 6'h08,
    EXC_CAUSE_ECALL_MMODE        = 6'h0b,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'h23,
    EXC_CAUSE_IRQ_TIMER_M        = 6'h27,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'h2b,
    EXC_CAUSE_IRQ_NM             = 6'h3f,
    // fast interrupts are 0x30 plus the index
    EXC_CAUSE_IRQ_FAST_0         = 6'h30,
    EXC_CAUSE_IRQ_FAST_14        = 6'h3e
  } exc_cause_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  ////////////////////
  // bundles
  ////////////////////

  // instruction held in the IF-ID register
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic [15:0] rdata_c;
    logic        is_compressed;
    logic        fetch_err;
    // error hit the upper half of an unaligned word
    logic        fetch_err_plus2;
    logic [31:0] pc;
  } instr_bus_t;

  // raw decoder flags, not yet qualified by valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_pipe_flush;
  } dec_flags_t;

  // interrupt requests after the mie mask
  typedef struct packed {
    logic        irq_software;
    logic        irq_timer;
    logic        irq_external;
    logic [14:0] irq_fast;
  } irqs_t;

  // exception unit report towards the FSM
  typedef struct packed {
    logic        special_req;
    logic        mret;
    logic        wfi;
    logic        csr_flush;
    logic        exc_pending;
    exc_cause_e  cause;
    logic [31:0] mtval;
  } exc_req_t;

  // redirect command to the fetch stage
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    exc_cause_e  cause;
  } pc_cmd_t;

  // CSR update command
  typedef struct packed {
    logic        save_if;
    logic        save_id;
    logic        restore_mret;
    logic        save_cause;
    logic [31:0] mtval;
  } csr_cmd_t;

endpackage

// File: logic/ctrl_exc_prio.sv
// no writeback stage: LSU errors belong to the instruction held in ID and rank below EBREAK
module ctrl_exc_prio import ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  instr_bus_t instr_i,
  input  dec_flags_t dec_i,
  input  priv_lvl_e  priv_lvl_i,
  input  logic       mstatus_tw_i,
  input  logic       load_err_i,
  input  logic       store_err_i,
  input  logic [31:0] lsu_addr_i,
  input  ctrl_fsm_e  fsm_state_i,
  output exc_req_t   exc_req_o,
  output logic       id_exception_o
);

  logic illegal_insn;
  logic ecall_insn;
  logic mret_insn;
  logic wfi_insn;
  logic ebrk_insn;
  logic csr_flush;
  logic fetch_err;
  logic illegal_umode;
  logic in_flush;

  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_d, load_err_q;
  logic store_err_d, store_err_q;

  exc_cause_e  cause;
  logic [31:0] mtval;

  ////////////////////
  // qualify decoder
  ////////////////////

  // decoder flags are raw, only trust them with a valid instruction
  assign illegal_insn = dec_i.illegal & instr_i.valid;
  assign ecall_insn   = dec_i.ecall & instr_i.valid;
  assign mret_insn    = dec_i.mret & instr_i.valid;
  assign wfi_insn     = dec_i.wfi & instr_i.valid;
  assign ebrk_insn    = dec_i.ebrk & instr_i.valid;
  assign csr_flush    = dec_i.csr_pipe_flush & instr_i.valid;
  assign fetch_err    = instr_i.fetch_err & instr_i.valid;

  assign in_flush = (fsm_state_i == FLUSH);

  // MRET, and WFI under mstatus.TW, are M-mode only
  assign illegal_umode = (priv_lvl_i != PRIV_LVL_M) & (mret_insn | (mstatus_tw_i & wfi_insn));

  // requests drop in FLUSH so a handled trap does not fire twice
  assign illegal_d   = (illegal_insn | illegal_umode) & ~in_flush;
  assign exc_req_d   = (ecall_insn | ebrk_insn | illegal_insn | illegal_umode | fetch_err) &
                       ~in_flush;
  assign load_err_d  = load_err_i & ~in_flush;
  assign store_err_d = store_err_i & ~in_flush;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_d;
      store_err_q <= store_err_d;
    end
  end

  ////////////////////
  // priority
  ////////////////////

  // fetch error, illegal, ecall, ebreak, store, load
  always_comb begin
    cause = EXC_CAUSE_INSN_ADDR_MISA;
    mtval = '0;
    if (fetch_err) begin
      cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
      mtval = instr_i.fetch_err_plus2 ? (instr_i.pc + 32'd2) : instr_i.pc;
    end else if (illegal_q) begin
      cause = EXC_CAUSE_ILLEGAL_INSN;
      mtval = instr_i.is_compressed ? {16'h0000, instr_i.rdata_c} : instr_i.rdata;
    end else if (ecall_insn) begin
      cause = (priv_lvl_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_insn) begin
      cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      mtval = lsu_addr_i;
    end else if (load_err_q) begin
      cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      mtval = lsu_addr_i;
    end
  end

  // LSU strobes come unqualified, they are not tied to a valid ID instruction
  assign exc_req_o.special_req = mret_insn | wfi_insn | csr_flush | exc_req_d |
                                 load_err_i | store_err_i;
  assign exc_req_o.mret        = mret_insn;
  assign exc_req_o.wfi         = wfi_insn;
  assign exc_req_o.csr_flush   = csr_flush;
  assign exc_req_o.exc_pending = exc_req_q | store_err_q | load_err_q;
  assign exc_req_o.cause       = cause;
  assign exc_req_o.mtval       = mtval;

  assign id_exception_o = exc_req_d;

endmodule

// File: logic/ctrl_irq_arb.sv
// irqs_i is already masked by mie; NumFastIrq from 1 to 15, higher fast bits are ignored
module ctrl_irq_arb import ctrl_pkg::*; #(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  input  logic       mstatus_mie_i,
  input  logic       nmi_enter_i,
  input  logic       nmi_exit_i,
  output logic       handle_irq_o,
  output logic       wake_req_o,
  output exc_cause_e irq_cause_o,
  output logic       nmi_mode_o
);

  logic [NumFastIrq-1:0] irq_fast;
  logic [3:0]            fast_idx;
  logic                  irq_pending;
  logic                  nmi_mode_q;

  assign irq_fast    = irqs_i.irq_fast[NumFastIrq-1:0];
  assign irq_pending = (|irq_fast) | irqs_i.irq_external | irqs_i.irq_software |
                       irqs_i.irq_timer;

  // no nesting, an NMI handler is never interrupted
  assign handle_irq_o = ~nmi_mode_q & (irq_nm_i | (irq_pending & mstatus_mie_i));

  // WFI wakes on any request, even with MIE clear
  assign wake_req_o = irq_nm_i | irq_pending;

  ////////////////////
  // cause select
  ////////////////////

  // lowest index wins, so scan downwards
  always_comb begin
    fast_idx = 4'd0;
    for (int i = NumFastIrq - 1; i >= 0; i--) begin
      if (irq_fast[i]) begin
        fast_idx = i[3:0];
      end
    end
  end

  always_comb begin
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (|irq_fast) begin
      // 0x30 plus index
      irq_cause_o = exc_cause_e'({2'b11, fast_idx});
    end else if (irqs_i.irq_external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // NMI mode, set on entry and cleared by MRET from the handler
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (nmi_enter_i) begin
      nmi_mode_q <= 1'b1;
    end else if (nmi_exit_i) begin
      nmi_mode_q <= 1'b0;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

endmodule

// File: logic/ctrl_fsm.sv
// interrupts enter only from DECODE with ID empty; pc_set is a one-cycle strobe, never acked
module ctrl_fsm import ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  exc_req_t   exc_req_i,
  input  logic       handle_irq_i,
  input  logic       wake_req_i,
  input  exc_cause_e irq_cause_i,
  input  logic       nmi_mode_i,
  input  logic       instr_valid_i,
  input  logic       branch_set_i,
  input  logic       jump_set_i,
  input  logic       stall_id_i,
  output ctrl_fsm_e  state_o,
  output pc_cmd_t    pc_cmd_o,
  output csr_cmd_t   csr_cmd_o,
  output logic       nmi_enter_o,
  output logic       nmi_exit_o,
  output logic       id_in_ready_o,
  output logic       instr_valid_clear_o,
  output logic       instr_req_o,
  output logic       ctrl_busy_o,
  output logic       controller_run_o,
  output logic       flush_id_o
);

  ctrl_fsm_e ctrl_fsm_cs, ctrl_fsm_ns;

  logic halt_if;
  logic retain_id;
  logic flush_id;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    ctrl_fsm_ns      = ctrl_fsm_cs;
    instr_req_o      = 1'b1;
    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    halt_if          = 1'b0;
    retain_id        = 1'b0;
    flush_id         = 1'b0;
    nmi_enter_o      = 1'b0;
    nmi_exit_o       = 1'b0;

    // mux fields only count while pc_set is high
    pc_cmd_o.pc_set     = 1'b0;
    pc_cmd_o.pc_mux     = PC_BOOT;
    pc_cmd_o.exc_pc_mux = EXC_PC_IRQ;
    pc_cmd_o.cause      = EXC_CAUSE_INSN_ADDR_MISA;

    csr_cmd_o.save_if      = 1'b0;
    csr_cmd_o.save_id      = 1'b0;
    csr_cmd_o.restore_mret = 1'b0;
    csr_cmd_o.save_cause   = 1'b0;
    csr_cmd_o.mtval        = '0;

    case (ctrl_fsm_cs)
      RESET: begin
        // no fetch yet, boot address goes out
        instr_req_o     = 1'b0;
        pc_cmd_o.pc_set = 1'b1;
        ctrl_fsm_ns     = BOOT_SET;
      end

      BOOT_SET: begin
        pc_cmd_o.pc_set = 1'b1;
        ctrl_fsm_ns     = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        // drain IF and ID before sleep
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        if (wake_req_i) begin
          ctrl_fsm_ns = FIRST_FETCH;
        end else begin
          // keep the clock gate closed
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for ID to take the first instruction
        if (id_in_ready_o) begin
          ctrl_fsm_ns = DECODE;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        pc_cmd_o.pc_mux  = PC_JUMP;

        // special request: keep instruction in ID for FLUSH
        if (exc_req_i.special_req) begin
          retain_id   = 1'b1;
          ctrl_fsm_ns = FLUSH;
        end

        if (branch_set_i || jump_set_i) begin
          pc_cmd_o.pc_set = 1'b1;
        end

        // irq waits for ID to drain, stop new fetches meanwhile
        if (handle_irq_i && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end

        if (!stall_id_i && !exc_req_i.special_req && !instr_valid_i && handle_irq_i) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_cmd_o.pc_mux     = PC_EXC;
        pc_cmd_o.exc_pc_mux = EXC_PC_IRQ;
        // request may have gone away, then just resume
        if (handle_irq_i) begin
          pc_cmd_o.pc_set      = 1'b1;
          pc_cmd_o.cause       = irq_cause_i;
          csr_cmd_o.save_if    = 1'b1;
          csr_cmd_o.save_cause = 1'b1;
          nmi_enter_o          = (irq_cause_i == EXC_CAUSE_IRQ_NM);
        end
        ctrl_fsm_ns = DECODE;
      end

      FLUSH: begin
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = DECODE;

        if (exc_req_i.exc_pending) begin
          // trap: epc from ID, cause and mtval from the priority unit
          pc_cmd_o.pc_set      = 1'b1;
          pc_cmd_o.pc_mux      = PC_EXC;
          pc_cmd_o.exc_pc_mux  = EXC_PC_EXC;
          pc_cmd_o.cause       = exc_req_i.cause;
          csr_cmd_o.save_id    = 1'b1;
          csr_cmd_o.save_cause = 1'b1;
          csr_cmd_o.mtval      = exc_req_i.mtval;
        end else if (exc_req_i.mret) begin
          pc_cmd_o.pc_set        = 1'b1;
          pc_cmd_o.pc_mux        = PC_ERET;
          csr_cmd_o.restore_mret = 1'b1;
          nmi_exit_o             = nmi_mode_i;
        end else if (exc_req_i.wfi) begin
          ctrl_fsm_ns = WAIT_SLEEP;
        end else if (exc_req_i.csr_flush && handle_irq_i) begin
          // CSR write may have just enabled an interrupt
          ctrl_fsm_ns = IRQ_TAKEN;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  ////////////////////
  // stall control
  ////////////////////

  // new instruction only when nothing holds ID
  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // a flush drops the instruction even when stalled or retained
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

  assign flush_id_o = flush_id;
  assign state_o    = ctrl_fsm_cs;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_fsm_cs <= RESET;
    end else begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
    end
  end

endmodule

// File: logic/ctrl_top.sv
// control unit without writeback stage, debug mode or branch prediction; NumFastIrq 1 to 15
module ctrl_top import ctrl_pkg::*; #(
  parameter int unsigned NumFastIrq = 15
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // ID stage
  input  instr_bus_t  instr_i,
  input  dec_flags_t  dec_i,
  // CSR state
  input  priv_lvl_e   priv_lvl_i,
  input  logic        mstatus_tw_i,
  input  logic        mstatus_mie_i,
  // interrupts
  input  irqs_t       irqs_i,
  input  logic        irq_nm_i,
  // LSU
  input  logic        load_err_i,
  input  logic        store_err_i,
  input  logic [31:0] lsu_addr_i,
  // EX
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        stall_id_i,
  // commands out
  output pc_cmd_t     pc_cmd_o,
  output csr_cmd_t    csr_cmd_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        instr_req_o,
  output logic        ctrl_busy_o,
  output logic        controller_run_o,
  output logic        flush_id_o,
  output logic        nmi_mode_o,
  output logic        id_exception_o
);

  exc_req_t   exc_req;
  ctrl_fsm_e  fsm_state;
  logic       handle_irq;
  logic       wake_req;
  exc_cause_e irq_cause;
  logic       nmi_enter;
  logic       nmi_exit;

  ////////////////////
  // exceptions
  ////////////////////

  ctrl_exc_prio i_exc_prio (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_i        (instr_i),
    .dec_i          (dec_i),
    .priv_lvl_i     (priv_lvl_i),
    .mstatus_tw_i   (mstatus_tw_i),
    .load_err_i     (load_err_i),
    .store_err_i    (store_err_i),
    .lsu_addr_i     (lsu_addr_i),
    .fsm_state_i    (fsm_state),
    .exc_req_o      (exc_req),
    .id_exception_o (id_exception_o)
  );

  // interrupts and NMI mode
  ctrl_irq_arb #(
    .NumFastIrq (NumFastIrq)
  ) i_irq_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irqs_i        (irqs_i),
    .irq_nm_i      (irq_nm_i),
    .mstatus_mie_i (mstatus_mie_i),
    .nmi_enter_i   (nmi_enter),
    .nmi_exit_i    (nmi_exit),
    .handle_irq_o  (handle_irq),
    .wake_req_o    (wake_req),
    .irq_cause_o   (irq_cause),
    .nmi_mode_o    (nmi_mode_o)
  );

  ctrl_fsm i_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .exc_req_i           (exc_req),
    .handle_irq_i        (handle_irq),
    .wake_req_i          (wake_req),
    .irq_cause_i         (irq_cause),
    .nmi_mode_i          (nmi_mode_o),
    .instr_valid_i       (instr_i.valid),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .stall_id_i          (stall_id_i),
    .state_o             (fsm_state),
    .pc_cmd_o            (pc_cmd_o),
    .csr_cmd_o           (csr_cmd_o),
    .nmi_enter_o         (nmi_enter),
    .nmi_exit_o          (nmi_exit),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .instr_req_o         (instr_req_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .controller_run_o    (controller_run_o),
    .flush_id_o          (flush_id_o)
  );

endmodule

// File: include/ctrl_tb_tasks.svh
// tasks run inside ctrl_tb and sample DUT outputs at the falling edge; every wait is bounded
`ifndef CTRL_TB_TASKS_SVH
`define CTRL_TB_TASKS_SVH

////////////////////
// compare
////////////////////

task automatic check_cause(input string name, input exc_cause_e exp, input exc_cause_e act);
  if (act !== exp) begin
    $display("ERR %s exp 0x%0h act 0x%0h at %0t", name, exp, act, $time);
    err_cnt++;
  end
endtask

task automatic check_pc_sel(input string name, input pc_sel_e exp, input pc_sel_e act);
  if (act !== exp) begin
    $display("ERR %s exp 0x%0h act 0x%0h at %0t", name, exp, act, $time);
    err_cnt++;
  end
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (act !== exp) begin
    $display("ERR %s exp 0x%0h act 0x%0h at %0t", name, exp, act, $time);
    err_cnt++;
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERR %s exp 0x%0h act 0x%0h at %0t", name, exp, act, $time);
    err_cnt++;
  end
endtask

////////////////////
// timing helpers
////////////////////

// inputs change 1 ns after the rising edge
task automatic next_drive_slot();
  @(posedge clk_i);
  #1;
endtask

// counts falling edges up to the first one with pc_set high
task automatic wait_pc_set(output int unsigned lat);
  @(negedge clk_i);
  lat = 1;
  while (!pc_cmd.pc_set && lat < wait_limit) begin
    @(negedge clk_i);
    lat++;
  end
  if (!pc_cmd.pc_set) begin
    $display("timeout: no PC redirect within %0d cycles at %0t", wait_limit, $time);
    err_cnt++;
  end
endtask

// controller_run is only high in DECODE
task automatic wait_decode();
  int unsigned cnt;
  cnt = 0;
  @(negedge clk_i);
  while (!controller_run && cnt < wait_limit) begin
    @(negedge clk_i);
    cnt++;
  end
  if (!controller_run) begin
    $display("timeout: controller never reached decode at %0t", $time);
    err_cnt++;
  end
endtask

task automatic wait_busy(input logic level);
  int unsigned cnt;
  cnt = 0;
  @(negedge clk_i);
  while (ctrl_busy !== level && cnt < wait_limit) begin
    @(negedge clk_i);
    cnt++;
  end
  if (ctrl_busy !== level) begin
    $display("timeout: ctrl_busy did not reach %0d at %0t", level, $time);
    err_cnt++;
  end
endtask

// hand one instruction to the IF-ID model, return once it sits in ID
task automatic present_instr(input instr_bus_t ins, input dec_flags_t flg);
  int unsigned cnt;
  cnt = 0;
  @(negedge clk_i);
  pend_instr = ins;
  pend_dec   = flg;
  pend_valid = 1'b1;
  while (pend_valid && cnt < wait_limit) begin
    @(negedge clk_i);
    cnt++;
  end
  if (pend_valid) begin
    $display("timeout: ID never accepted the instruction at %0t", $time);
    err_cnt++;
    pend_valid = 1'b0;
  end
endtask

// no redirect may appear within the given number of cycles
task automatic expect_no_redirect(input string name, input int unsigned cycles);
  logic seen;
  seen = 1'b0;
  repeat (cycles) begin
    @(negedge clk_i);
    seen = seen | pc_cmd.pc_set;
  end
  check_flag(name, 1'b0, seen);
endtask

////////////////////
// trap checks
////////////////////

// trap must redirect one cycle after DECODE and for one cycle only
task automatic verify_trap(input exc_cause_e exp_cause, input logic [31:0] exp_mtval);
  int unsigned lat;
  wait_pc_set(lat);
  check_word("trap latency", 32'd1, lat);
  check_pc_sel("pc_mux", PC_EXC, pc_cmd.pc_mux);
  check_flag("exc_pc_mux", EXC_PC_EXC, pc_cmd.exc_pc_mux);
  check_cause("pc_cmd.cause", exp_cause, pc_cmd.cause);
  check_word("csr_cmd.mtval", exp_mtval, csr_cmd.mtval);
  check_flag("save_id", 1'b1, csr_cmd.save_id);
  check_flag("save_cause", 1'b1, csr_cmd.save_cause);
  // the trapping instruction leaves ID in the redirect cycle
  check_flag("flush_id", 1'b1, flush_id);
  check_flag("instr_valid_clear", 1'b1, instr_valid_clear);
  next_drive_slot();
  @(negedge clk_i);
  check_flag("pc_set after trap", 1'b0, pc_cmd.pc_set);
endtask

// checks an interrupt entry and then drops the request as a handler would
task automatic verify_irq(input exc_cause_e exp_cause, input int unsigned exp_lat);
  int unsigned lat;
  wait_pc_set(lat);
  check_word("irq latency", exp_lat, lat);
  check_pc_sel("pc_mux", PC_EXC, pc_cmd.pc_mux);
  check_flag("exc_pc_mux", EXC_PC_IRQ, pc_cmd.exc_pc_mux);
  check_cause("pc_cmd.cause", exp_cause, pc_cmd.cause);
  check_flag("save_if", 1'b1, csr_cmd.save_if);
  next_drive_slot();
  irqs   = '0;
  irq_nm = 1'b0;
  @(negedge clk_i);
  check_flag("pc_set after irq", 1'b0, pc_cmd.pc_set);
endtask

`endif

// File: verif/ctrl_tb.sv
// directed testbench of ctrl_top; ID is a one-entry model, CSRs and LSU are plain stimulus
module ctrl_tb import ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned wait_limit = 50;

  logic        clk_i;
  logic        rst_ni;
  instr_bus_t  instr;
  dec_flags_t  dec;
  priv_lvl_e   priv_lvl;
  logic        mstatus_tw;
  logic        mstatus_mie;
  irqs_t       irqs;
  logic        irq_nm;
  logic        load_err;
  logic        store_err;
  logic [31:0] lsu_addr;
  logic        branch_set;
  logic        jump_set;
  logic        stall_id;

  pc_cmd_t     pc_cmd;
  csr_cmd_t    csr_cmd;
  logic        id_in_ready;
  logic        instr_valid_clear;
  logic        instr_req;
  logic        ctrl_busy;
  logic        controller_run;
  logic        flush_id;
  logic        nmi_mode;
  logic        id_exception;

  // IF-ID model state
  instr_bus_t  pend_instr;
  dec_flags_t  pend_dec;
  logic        pend_valid;
  logic        ready_smp = 1'b0;
  logic        clear_smp = 1'b0;

  integer      seed;
  int unsigned err_cnt;

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  ctrl_top #(
    .NumFastIrq (15)
  ) i_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_i             (instr),
    .dec_i               (dec),
    .priv_lvl_i          (priv_lvl),
    .mstatus_tw_i        (mstatus_tw),
    .mstatus_mie_i       (mstatus_mie),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .load_err_i          (load_err),
    .store_err_i         (store_err),
    .lsu_addr_i          (lsu_addr),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .stall_id_i          (stall_id),
    .pc_cmd_o            (pc_cmd),
    .csr_cmd_o           (csr_cmd),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear),
    .instr_req_o         (instr_req),
    .ctrl_busy_o         (ctrl_busy),
    .controller_run_o    (controller_run),
    .flush_id_o          (flush_id),
    .nmi_mode_o          (nmi_mode),
    .id_exception_o      (id_exception)
  );

  ////////////////////
  // IF-ID model
  ////////////////////

  // handshake seen in the middle of the cycle and acted on after the edge
  always @(negedge clk_i) begin
    ready_smp = id_in_ready;
    clear_smp = instr_valid_clear;
  end

  // load when ID is ready, otherwise drop on clear, otherwise hold
  always @(posedge clk_i) begin
    #1;
    if (ready_smp && pend_valid) begin
      instr      = pend_instr;
      dec        = pend_dec;
      pend_valid = 1'b0;
    end else if (clear_smp) begin
      instr.valid = 1'b0;
      dec         = '0;
    end
  end

  // random word, half and halfword-aligned pc
  function automatic instr_bus_t random_instr();
    instr_bus_t ins;
    ins         = '0;
    ins.valid   = 1'b1;
    ins.rdata   = $random(seed);
    ins.rdata_c = $random(seed);
    ins.pc      = $random(seed) & 32'hffff_fffe;
    return ins;
  endfunction

  // fast cause is 0x30 plus the lowest set index
  function automatic exc_cause_e lowest_fast_cause(input logic [14:0] fast);
    logic [5:0] code;
    logic       found;
    code  = 6'h00;
    found = 1'b0;
    for (int i = 0; i < 15; i++) begin
      if (fast[i] && !found) begin
        code  = 6'h30 + i[5:0];
        found = 1'b1;
      end
    end
    return exc_cause_e'(code);
  endfunction

  `include "ctrl_tb_tasks.svh"

  ////////////////////
  // directed tests
  ////////////////////

  task automatic boot_sequence();
    @(negedge clk_i);
    check_flag("pc_set in RESET", 1'b1, pc_cmd.pc_set);
    check_pc_sel("pc_mux in RESET", PC_BOOT, pc_cmd.pc_mux);
    check_flag("instr_req in RESET", 1'b0, instr_req);
    check_flag("ctrl_busy in RESET", 1'b1, ctrl_busy);
    @(negedge clk_i);
    check_flag("pc_set in BOOT_SET", 1'b1, pc_cmd.pc_set);
    check_pc_sel("pc_mux in BOOT_SET", PC_BOOT, pc_cmd.pc_mux);
    @(negedge clk_i);
    check_flag("pc_set after boot", 1'b0, pc_cmd.pc_set);
    check_flag("id_in_ready after boot", 1'b1, id_in_ready);
    wait_decode();
  endtask

  task automatic ecall_privilege();
    instr_bus_t ins;
    dec_flags_t flg;
    flg      = '0;
    flg.ecall = 1'b1;
    present_instr(random_instr(), flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_ECALL_MMODE, 32'h0);
    next_drive_slot();
    priv_lvl = PRIV_LVL_U;
    present_instr(random_instr(), flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_ECALL_UMODE, 32'h0);
    // MRET is M-mode only
    flg      = '0;
    flg.mret = 1'b1;
    ins      = random_instr();
    present_instr(ins, flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_ILLEGAL_INSN, ins.rdata);
    next_drive_slot();
    priv_lvl = PRIV_LVL_M;
  endtask

  task automatic illegal_and_fetch_error();
    instr_bus_t ins;
    dec_flags_t flg;
    flg         = '0;
    flg.illegal = 1'b1;
    ins         = random_instr();
    present_instr(ins, flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_ILLEGAL_INSN, ins.rdata);
    ins               = random_instr();
    ins.is_compressed = 1'b1;
    present_instr(ins, flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_ILLEGAL_INSN, {16'h0000, ins.rdata_c});
    // fetch error in the lower and then the upper half
    flg           = '0;
    ins           = random_instr();
    ins.fetch_err = 1'b1;
    present_instr(ins, flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_INSTR_ACCESS_FAULT, ins.pc);
    ins                 = random_instr();
    ins.fetch_err       = 1'b1;
    ins.fetch_err_plus2 = 1'b1;
    present_instr(ins, flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_INSTR_ACCESS_FAULT, ins.pc + 32'd2);
    // fetch error outranks illegal
    flg.illegal   = 1'b1;
    ins           = random_instr();
    ins.fetch_err = 1'b1;
    present_instr(ins, flg);
    check_flag("id_exception", 1'b1, id_exception);
    verify_trap(EXC_CAUSE_INSTR_ACCESS_FAULT, ins.pc);
  endtask

  task automatic lsu_errors();
    logic [31:0] addr;
    addr = $random(seed);
    next_drive_slot();
    lsu_addr  = addr;
    store_err = 1'b1;
    next_drive_slot();
    store_err = 1'b0;
    verify_trap(EXC_CAUSE_STORE_ACCESS_FAULT, addr);
    addr = $random(seed);
    next_drive_slot();
    lsu_addr = addr;
    load_err = 1'b1;
    next_drive_slot();
    load_err = 1'b0;
    verify_trap(EXC_CAUSE_LOAD_ACCESS_FAULT, addr);
    // store ranks above load
    addr = $random(seed);
    next_drive_slot();
    lsu_addr  = addr;
    load_err  = 1'b1;
    store_err = 1'b1;
    next_drive_slot();
    load_err  = 1'b0;
    store_err = 1'b0;
    verify_trap(EXC_CAUSE_STORE_ACCESS_FAULT, addr);
  endtask

  task automatic interrupts_and_nmi();
    dec_flags_t  flg;
    int unsigned lat;
    next_drive_slot();
    mstatus_mie       = 1'b1;
    irqs.irq_fast     = 15'h0250;
    irqs.irq_external = 1'b1;
    verify_irq(lowest_fast_cause(15'h0250), 2);
    next_drive_slot();
    irq_nm = 1'b1;
    // NMI code 31 with the interrupt bit
    verify_irq(exc_cause_e'({1'b1, 5'd31}), 2);
    check_flag("nmi_mode after NMI", 1'b1, nmi_mode);
    // no nesting inside the NMI handler
    next_drive_slot();
    irq_nm = 1'b1;
    expect_no_redirect("pc_set on second NMI", 6);
    next_drive_slot();
    irq_nm   = 1'b0;
    flg      = '0;
    flg.mret = 1'b1;
    present_instr(random_instr(), flg);
    wait_pc_set(lat);
    check_word("mret latency", 32'd1, lat);
    check_pc_sel("pc_mux on mret", PC_ERET, pc_cmd.pc_mux);
    check_flag("restore_mret", 1'b1, csr_cmd.restore_mret);
    next_drive_slot();
    @(negedge clk_i);
    check_flag("nmi_mode after mret", 1'b0, nmi_mode);
    // MIE clear blocks regular interrupts
    next_drive_slot();
    mstatus_mie    = 1'b0;
    irqs.irq_timer = 1'b1;
    expect_no_redirect("pc_set with MIE clear", 6);
    // a stall holds ID and defers the pending timer interrupt
    next_drive_slot();
    stall_id    = 1'b1;
    mstatus_mie = 1'b1;
    expect_no_redirect("pc_set while stalled", 4);
    check_flag("id_in_ready while stalled", 1'b0, id_in_ready);
    check_flag("instr_valid_clear while stalled", 1'b0, instr_valid_clear);
    next_drive_slot();
    stall_id = 1'b0;
    verify_irq(EXC_CAUSE_IRQ_TIMER_M, 2);
  endtask

  task automatic wfi_sleep();
    dec_flags_t flg;
    logic       woke;
    next_drive_slot();
    mstatus_mie = 1'b1;
    flg         = '0;
    flg.wfi     = 1'b1;
    present_instr(random_instr(), flg);
    wait_busy(1'b0);
    woke = 1'b0;
    repeat (6) begin
      @(negedge clk_i);
      woke = woke | ctrl_busy;
    end
    check_flag("ctrl_busy while asleep", 1'b0, woke);
    check_flag("instr_req while asleep", 1'b0, instr_req);
    next_drive_slot();
    irqs.irq_software = 1'b1;
    @(negedge clk_i);
    check_flag("ctrl_busy on wake", 1'b1, ctrl_busy);
    // FIRST_FETCH and DECODE come before IRQ_TAKEN
    verify_irq(EXC_CAUSE_IRQ_SOFTWARE_M, 3);
    wait_decode();
  endtask

  initial begin
    seed        = 32'h9d90;
    err_cnt     = 0;
    rst_ni      = 1'b0;
    instr       = '0;
    dec         = '0;
    priv_lvl    = PRIV_LVL_M;
    mstatus_tw  = 1'b0;
    mstatus_mie = 1'b0;
    irqs        = '0;
    irq_nm      = 1'b0;
    load_err    = 1'b0;
    store_err   = 1'b0;
    lsu_addr    = '0;
    branch_set  = 1'b0;
    jump_set    = 1'b0;
    stall_id    = 1'b0;
    pend_instr  = '0;
    pend_dec    = '0;
    pend_valid  = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    boot_sequence();
    ecall_privilege();
    illegal_and_fetch_error();
    lsu_errors();
    interrupts_and_nmi();
    wfi_sleep();

    repeat (2) @(posedge clk_i);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+include
logic/ctrl_pkg.sv
logic/ctrl_exc_prio.sv
logic/ctrl_irq_arb.sv
logic/ctrl_fsm.sv
logic/ctrl_top.sv
verif/ctrl_tb.sv

// File: Bender.yml
package:
  name: ctrl_unit

sources:
  - logic/ctrl_pkg.sv
  - logic/ctrl_exc_prio.sv
  - logic/ctrl_irq_arb.sv
  - logic/ctrl_fsm.sv
  - logic/ctrl_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/ctrl_tb.sv
